// File: hdl/ravenoc_cfg.svh
`ifndef RAVENOC_CFG_SVH
`define RAVENOC_CFG_SVH

// Mesh dimensions in routers
// These set the width of the destination coordinate fields in a head flit
`define RAVENOC_NOC_X 4
`define RAVENOC_NOC_Y 4

// Depth of the buffer at every input port, counted in flits
`define RAVENOC_FIFO_DEPTH 4

// Width of the data word carried by one flit
// The head view splits this word into coordinates and a head payload
`define RAVENOC_DATA_W 32

// A flit is the data word plus two bits of flit type
// Changing the data width therefore changes the flit width by the same amount

// All routers of one mesh share these values

`endif

// File: hdl/ravenoc_pkg.sv
`include "ravenoc_cfg.svh"

package ravenoc_pkg;

  localparam int X_W       = $clog2(`RAVENOC_NOC_X);
  localparam int Y_W       = $clog2(`RAVENOC_NOC_Y);
  localparam int HEAD_PL_W = `RAVENOC_DATA_W - X_W - Y_W;

  // Port numbering used for every five-entry array in the router
  typedef enum logic [2:0] {
    NORTH_PORT = 3'd0,
    SOUTH_PORT = 3'd1,
    WEST_PORT  = 3'd2,
    EAST_PORT  = 3'd3,
    LOCAL_PORT = 3'd4
  } router_port_t;

  typedef enum logic [1:0] {
    HEAD_FLIT,
    BODY_FLIT,
    TAIL_FLIT,
    HEAD_TAIL_FLIT
  } flit_type_t;

  typedef struct packed {
    logic [X_W-1:0]       x_dest;
    logic [Y_W-1:0]       y_dest;
    logic [HEAD_PL_W-1:0] payload;
  } s_head_t;

  // The same word is a head or plain payload depending on the flit type
  typedef union packed {
    s_head_t                   head;
    logic [`RAVENOC_DATA_W-1:0] body;
  } u_flit_data_t;

  typedef struct packed {
    flit_type_t   flit_type;
    u_flit_data_t data;
  } s_flit_t;

  typedef struct packed {
    logic north_req;
    logic south_req;
    logic west_req;
    logic east_req;
    logic local_req;
  } s_router_ports_t;

  // Picks the request bit of one output port out of a route
  function automatic logic route_bit(s_router_ports_t route, router_port_t port);
    case (port)
      NORTH_PORT: return route.north_req;
      SOUTH_PORT: return route.south_req;
      WEST_PORT:  return route.west_req;
      EAST_PORT:  return route.east_req;
      default:    return route.local_req;
    endcase
  endfunction

endpackage

// File: hdl/router_if.sv
`timescale 1ns/1ps

// Link between one input module and the output side of the router
interface router_if import ravenoc_pkg::*; ();

  logic            valid;
  s_flit_t         flit;
  s_router_ports_t route;
  logic            ready;

  modport send_flit (
    output valid,
    output flit,
    output route,
    input  ready
  );

  // Output modules only read the link
  // Ready is formed at the top level
  modport recv_flit (
    input valid,
    input flit,
    input route
  );

endinterface

// File: hdl/input_module.sv
`timescale 1ns/1ps
`include "ravenoc_cfg.svh"

module input_module import ravenoc_pkg::*; #(
  parameter int ROUTER_X_ID = 0,
  parameter int ROUTER_Y_ID = 0
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  s_flit_t     in_flit_i,
  router_if.send_flit fout
);

  localparam int DEPTH = `RAVENOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  s_flit_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  s_flit_t          head_flit;
  logic             is_head;
  logic             is_last;
  s_router_ports_t  route_calc;
  s_router_ports_t  route_q;
  logic             route_hold_q;

  assign in_ready_o = (count != CNT_W'(DEPTH));
  assign push       = in_valid_i && in_ready_o;
  assign pop        = fout.valid && fout.ready;

  assign head_flit = mem[rd_ptr];
  assign is_head   = head_flit.flit_type inside {HEAD_FLIT, HEAD_TAIL_FLIT};
  assign is_last   = head_flit.flit_type inside {TAIL_FLIT, HEAD_TAIL_FLIT};

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // XY routing resolves the X offset first
  always_comb begin : xy_route
    route_calc = '0;
    if (int'(head_flit.data.head.x_dest) > ROUTER_X_ID) begin
      route_calc.east_req = 1'b1;
    end else if (int'(head_flit.data.head.x_dest) < ROUTER_X_ID) begin
      route_calc.west_req = 1'b1;
    end else if (int'(head_flit.data.head.y_dest) > ROUTER_Y_ID) begin
      route_calc.north_req = 1'b1;
    end else if (int'(head_flit.data.head.y_dest) < ROUTER_Y_ID) begin
      route_calc.south_req = 1'b1;
    end else begin
      route_calc.local_req = 1'b1;
    end
  end

  // Body and tail flits carry no address, so the head's route is kept
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      route_q      <= '0;
      route_hold_q <= 1'b0;
    end else if (pop && is_head && !is_last) begin
      route_q      <= route_calc;
      route_hold_q <= 1'b1;
    end else if (pop && is_last) begin
      route_hold_q <= 1'b0;
    end
  end

  assign fout.valid = (count != '0);
  assign fout.flit  = head_flit;
  assign fout.route = route_hold_q ? route_q :
                      (fout.valid && is_head) ? route_calc : '0;

endmodule

// File: hdl/output_module.sv
`timescale 1ns/1ps

module output_module import ravenoc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  router_if.recv_flit fin [5],
  input  logic [4:0]  req_i,
  output logic [4:0]  grant_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output s_flit_t     out_flit_o
);

  logic [4:0]          valid_in;
  s_flit_t [4:0]       flit_in;
  logic [4:0]          req_act;
  logic [4:0]          pick;
  logic                lock_q;
  logic [4:0]          owner_q;
  logic [2:0]          rr_ptr_q;
  logic [2:0]          grant_idx;
  logic [2:0]          next_ptr;
  s_flit_t             sel_flit;
  logic                sel_valid;
  logic                stage_ready;
  logic                xfer;

  for (genvar g = 0; g < 5; g++) begin : g_fin
    assign valid_in[g] = fin[g].valid;
    assign flit_in[g]  = fin[g].flit;
  end

  assign req_act = req_i & valid_in;

  // Search starts at the input after the one that last finished a packet
  always_comb begin : rr_pick
    int  idx;
    logic found;
    pick  = '0;
    found = 1'b0;
    for (int k = 0; k < 5; k++) begin
      idx = int'(rr_ptr_q) + k;
      if (idx >= 5) begin
        idx = idx - 5;
      end
      if (!found && req_act[idx]) begin
        pick[idx] = 1'b1;
        found     = 1'b1;
      end
    end
  end

  // A locked output keeps serving one input until its tail has passed
  assign grant_o = lock_q ? owner_q : pick;

  always_comb begin : grant_mux
    sel_flit  = '0;
    grant_idx = '0;
    for (int g = 0; g < 5; g++) begin
      if (grant_o[g]) begin
        sel_flit  = flit_in[g];
        grant_idx = 3'(g);
      end
    end
  end

  assign sel_valid   = |(grant_o & valid_in);
  assign stage_ready = !out_valid_o || out_ready_i;
  assign xfer        = sel_valid && stage_ready;
  assign next_ptr    = (grant_idx == 3'd4) ? 3'd0 : grant_idx + 3'd1;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q      <= 1'b0;
      owner_q     <= '0;
      rr_ptr_q    <= '0;
      out_valid_o <= 1'b0;
    end else begin
      if (stage_ready) begin
        out_valid_o <= xfer;
      end
      if (xfer && sel_flit.flit_type == HEAD_FLIT) begin
        lock_q  <= 1'b1;
        owner_q <= grant_o;
      end else if (xfer && sel_flit.flit_type inside {TAIL_FLIT, HEAD_TAIL_FLIT}) begin
        lock_q   <= 1'b0;
        rr_ptr_q <= next_ptr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      out_flit_o <= sel_flit;
    end
  end

endmodule

// File: hdl/router_ravenoc.sv
`timescale 1ns/1ps

module router_ravenoc import ravenoc_pkg::*; #(
  parameter int ROUTER_X_ID = 0,
  parameter int ROUTER_Y_ID = 0
) (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic [4:0]    in_valid_i,
  output logic [4:0]    in_ready_o,
  input  s_flit_t [4:0] in_flit_i,
  output logic [4:0]    out_valid_o,
  input  logic [4:0]    out_ready_i,
  output s_flit_t [4:0] out_flit_o
);

  router_if in_if [5] ();

  s_router_ports_t [4:0] route_v;
  logic [4:0]            req_map [5];
  logic [4:0]            grant   [5];
  logic [4:0]            stage_rdy;
  logic [4:0]            in_rdy;

  for (genvar i = 0; i < 5; i++) begin : g_input
    input_module #(
      .ROUTER_X_ID (ROUTER_X_ID),
      .ROUTER_Y_ID (ROUTER_Y_ID)
    ) u_input_module (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .in_valid_i (in_valid_i[i]),
      .in_ready_o (in_ready_o[i]),
      .in_flit_i  (in_flit_i[i]),
      .fout       (in_if[i])
    );
    assign route_v[i]     = in_if[i].route;
    assign in_if[i].ready = in_rdy[i];
  end

  for (genvar o = 0; o < 5; o++) begin : g_output
    output_module u_output_module (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .fin         (in_if),
      .req_i       (req_map[o]),
      .grant_o     (grant[o]),
      .out_valid_o (out_valid_o[o]),
      .out_ready_i (out_ready_i[o]),
      .out_flit_o  (out_flit_o[o])
    );
    assign stage_rdy[o] = !out_valid_o[o] || out_ready_i[o];
  end

  // Each output sees one column of the route matrix, indexed by input port
  always_comb begin : route_map
    for (int o = 0; o < 5; o++) begin
      for (int i = 0; i < 5; i++) begin
        req_map[o][i] = route_bit(route_v[i], router_port_t'(o));
      end
    end
  end

  // An input moves a flit only through the output that granted it
  always_comb begin : ready_map
    in_rdy = '0;
    for (int o = 0; o < 5; o++) begin
      in_rdy = in_rdy | (grant[o] & {5{stage_rdy[o]}});
    end
  end

endmodule

// File: tests/router_properties.sv
`timescale 1ns/1ps

module router_properties import ravenoc_pkg::*; (
  input logic          clk,
  input logic          rst_n_i,
  input logic [4:0]    in_ready_i,
  input logic [4:0]    fifo_full_i,
  input logic [4:0]    out_valid_i,
  input logic [4:0]    out_ready_i,
  input s_flit_t [4:0] out_flit_i,
  input logic [4:0]    grant_i [5]
);

  int assert_errors;

  for (genvar p = 0; p < 5; p++) begin : g_port
    // A stalled output keeps both its valid and its flit
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid_i[p] && !out_ready_i[p] |=> out_valid_i[p] && $stable(out_flit_i[p]))
      else begin
        assert_errors++;
        $error("Output %0d changed its flit while stalled", p);
      end

    // Wormhole switching allows one input per output at a time
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(grant_i[p]))
      else begin
        assert_errors++;
        $error("Output %0d granted more than one input", p);
      end

    // Equal FIFO pointers with a flit waiting mean the buffer is full
    a_full_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
      fifo_full_i[p] |-> !in_ready_i[p])
      else begin
        assert_errors++;
        $error("Input %0d accepts flits with a full buffer", p);
      end
  end

endmodule

bind router_ravenoc router_properties u_router_properties (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .in_ready_i  (in_ready_o),
  .fifo_full_i ({g_input[4].u_input_module.wr_ptr == g_input[4].u_input_module.rd_ptr &&
                   g_input[4].u_input_module.count != '0,
                 g_input[3].u_input_module.wr_ptr == g_input[3].u_input_module.rd_ptr &&
                   g_input[3].u_input_module.count != '0,
                 g_input[2].u_input_module.wr_ptr == g_input[2].u_input_module.rd_ptr &&
                   g_input[2].u_input_module.count != '0,
                 g_input[1].u_input_module.wr_ptr == g_input[1].u_input_module.rd_ptr &&
                   g_input[1].u_input_module.count != '0,
                 g_input[0].u_input_module.wr_ptr == g_input[0].u_input_module.rd_ptr &&
                   g_input[0].u_input_module.count != '0}),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_flit_i  (out_flit_o),
  .grant_i     (grant)
);

// File: tests/tb_router_ravenoc.sv
`timescale 1ns/1ps

module tb_router_ravenoc import ravenoc_pkg::*; ();

  localparam int unsigned SEED      = 32'hd82670fe;
  localparam string       STIM_FILE = "tests/router_stimulus.txt";

  logic          clk;
  logic          rst_n_i;
  logic [4:0]    in_valid_i;
  logic [4:0]    in_ready_o;
  s_flit_t [4:0] in_flit_i;
  logic [4:0]    out_valid_o;
  logic [4:0]    out_ready_i;
  s_flit_t [4:0] out_flit_o;

  // One entry per stimulus line
  s_flit_t      rec_flit [$];
  router_port_t rec_exp  [$];
  // Flits still to be driven on each input port
  int           drv_q    [5][$];
  // Accepted flits not yet seen, indexed by expected output * 5 + source
  int           exp_q    [25][$];
  // Queue that each output drains inside a packet or -1 between packets
  int           cur_q    [5];
  int           seen;
  int           cycles;
  int           limit;
  int           err_flit;
  int           err_port;
  int           err_status;
  int           err_other;

  router_ravenoc #(
    .ROUTER_X_ID (1),
    .ROUTER_Y_ID (1)
  ) dut_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_flit_i   (in_flit_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_flit_o  (out_flit_o)
  );

  always #10 clk = ~clk;

  task automatic check_flit(s_flit_t got, s_flit_t exp, router_port_t port);
    if (got !== exp) begin
      err_flit++;
      $display("ERROR %0t: %s output gave flit %h, expected %h",
               $time, port.name(), got, exp);
    end
  endtask

  task automatic check_port(router_port_t got, router_port_t exp, s_flit_t flit);
    if (got !== exp) begin
      err_port++;
      $display("ERROR %0t: flit %h left on %s, expected %s",
               $time, flit, got.name(), exp.name());
    end
  endtask

  task automatic check_status(logic [4:0] got, logic [4:0] exp, string what);
    if (got !== exp) begin
      err_status++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          p;
    int          t;
    int          e;
    logic [31:0] d;
    string       line;
    s_flit_t     f;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      err_other++;
      $display("Could not open the stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%d %d %h %d", p, t, d, e);
        if (n == 4 && p < 5 && e < 5) begin
          f.flit_type = flit_type_t'(t);
          f.data.body = d;
          drv_q[p].push_back(rec_flit.size());
          rec_flit.push_back(f);
          rec_exp.push_back(router_port_t'(e));
        end
      end
    end
    $fclose(fd);
  endtask

  // Heads are matched against every pending queue
  // The rest of a packet must come from the queue its head came from
  task automatic take_output(router_port_t o, s_flit_t got);
    int q;
    int idx;
    q = cur_q[o];
    if (q < 0) begin
      for (int k = 0; k < 25; k++) begin
        if (q < 0 && exp_q[k].size() > 0 && rec_flit[exp_q[k][0]] === got) begin
          q = k;
        end
      end
    end
    if (q < 0 || exp_q[q].size() == 0) begin
      err_other++;
      $display("Unexpected flit %h appeared on the %s output", got, o.name());
      return;
    end
    idx = exp_q[q].pop_front();
    seen++;
    check_port(o, rec_exp[idx], got);
    check_flit(got, rec_flit[idx], o);
    if (rec_flit[idx].flit_type == HEAD_FLIT) begin
      cur_q[o] = q;
    end else if (rec_flit[idx].flit_type inside {TAIL_FLIT, HEAD_TAIL_FLIT}) begin
      cur_q[o] = -1;
    end
  endtask

  task automatic sample_ports();
    int idx;
    for (int p = 0; p < 5; p++) begin
      if (in_valid_i[p] && in_ready_o[p]) begin
        idx = drv_q[p].pop_front();
        exp_q[int'(rec_exp[idx]) * 5 + p].push_back(idx);
      end
    end
    for (int o = 0; o < 5; o++) begin
      if (out_valid_o[o] && out_ready_i[o]) begin
        take_output(router_port_t'(o), out_flit_o[o]);
      end
    end
  endtask

  // The front of each queue stays on the pins until it is accepted
  task automatic drive_ports();
    for (int p = 0; p < 5; p++) begin
      if (drv_q[p].size() > 0) begin
        in_valid_i[p] = 1'b1;
        in_flit_i[p]  = rec_flit[drv_q[p][0]];
      end else begin
        in_valid_i[p] = 1'b0;
        in_flit_i[p]  = '0;
      end
      out_ready_i[p] = ($urandom % 4) != 0;
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    in_valid_i  = '0;
    in_flit_i   = '0;
    out_ready_i = '0;
    void'($urandom(SEED));
    for (int o = 0; o < 5; o++) begin
      cur_q[o] = -1;
    end
    load_stimulus();
    limit = 40 * rec_flit.size() + 100;
    repeat (5) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    check_status(in_ready_o, 5'b11111, "in_ready_o after reset");
    check_status(out_valid_o, 5'b00000, "out_valid_o after reset");
    drive_ports();
    while (seen < rec_flit.size() && cycles < limit) begin
      @(posedge clk);
      cycles++;
      sample_ports();
      #2;
      drive_ports();
    end
    if (seen < rec_flit.size()) begin
      err_other++;
      $display("Run stopped at the limit of %0d cycles with %0d of %0d flits seen",
               limit, seen, rec_flit.size());
    end
    // Anything that still leaves the router now is a duplicate
    out_ready_i = '1;
    repeat (10) begin
      @(posedge clk);
      sample_ports();
    end
    $display("Errors: flit %0d, port %0d, status %0d, assertion %0d, other %0d",
             err_flit, err_port, err_status,
             dut_i.u_router_properties.assert_errors, err_other);
    if (err_flit + err_port + err_status + err_other +
        dut_i.u_router_properties.assert_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tests/router_stimulus.txt
# in_port flit_type data_hex expected_out_port, one flit per line
# ports 0=north 1=south 2=west 3=east 4=local, types 0=head 1=body 2=tail 3=head_tail
2 3 90000001 3
3 3 10000002 2
1 3 60000003 0
0 3 40000004 1
0 3 50000005 4
4 0 60000010 0
4 1 00000011 0
4 1 00000012 0
4 2 00000013 0
2 0 A0000020 3
2 1 00000021 3
2 1 00000022 3
2 2 00000023 3
1 0 F0000030 3
1 1 00000031 3
1 2 00000032 3
4 3 B0000040 3
3 0 40000050 1
3 2 00000051 1

// File: list.f
+incdir+hdl
hdl/ravenoc_pkg.sv
hdl/router_if.sv
hdl/input_module.sv
hdl/output_module.sv
hdl/router_ravenoc.sv
tests/router_properties.sv
tests/tb_router_ravenoc.sv

// File: Bender.yml
package:
  name: router_ravenoc

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ravenoc_pkg.sv
      - hdl/router_if.sv
      - hdl/input_module.sv
      - hdl/output_module.sv
      - hdl/router_ravenoc.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/router_properties.sv
      - tests/tb_router_ravenoc.sv
